/* wb_soc_settings.svh */
`ifndef WB_SOC_SETTINGS_SVH
`define WB_SOC_SETTINGS_SVH

//////////////////////////////
// Bus geometry
`define WB_AW           32
`define WB_DW           32
`define WB_SEL_W        4
`define WB_BOFS_W       2    // Byte offset inside a word
`define WB_NUM_MASTERS  2

// Main RAM, 1024 words
`define WB_MEM_ADR_BITS 10

//////////////////////////////
// Address map
`define WB_REGION_W     7
`define WB_RAM_REGION   7'h00
`define WB_UART_REG_W   3
`define WB_UART_PAGE    29'h1FF0_0000  // 0xFF800000 >> 3

// UART
`define UART_BIT_CYCLES 16
`define UART_REG_THR    3'd0
`define UART_REG_LSR    3'd5

`endif

/* wb_soc_pkg.sv */
`default_nettype none

`include "wb_soc_settings.svh"

package wb_soc_pkg;

   // Address as seen by the RAM
   typedef struct packed {
      logic [`WB_REGION_W-1:0]                       region;
      logic [`WB_AW-`WB_REGION_W-`WB_BOFS_W-1:0]     word;
      logic [`WB_BOFS_W-1:0]                         byte_ofs;
   } wb_adr_ram_t;

   // Address as seen by the UART
   typedef struct packed {
      logic [`WB_AW-`WB_UART_REG_W-1:0] page;
      logic [`WB_UART_REG_W-1:0]        reg_ofs;
   } wb_adr_uart_t;

   typedef union packed {
      wb_adr_ram_t  ram;
      wb_adr_uart_t uart;
   } wb_adr_u;

   typedef struct packed {
      wb_adr_u               adr;
      logic [`WB_DW-1:0]     dat;
      logic [`WB_SEL_W-1:0]  sel;
      logic                  we;
      logic                  cyc;
      logic                  stb;
   } wb_req_t;

   typedef struct packed {
      logic [`WB_DW-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   // Byte wide side of the UART bridge
   typedef struct packed {
      wb_adr_u    adr;
      logic [7:0] dat;
      logic       we;
      logic       cyc;
      logic       stb;
   } wb8_req_t;

   typedef struct packed {
      logic [7:0] dat;
      logic       ack;
   } wb8_rsp_t;

endpackage

`default_nettype wire

/* wb_soc_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module wb_soc_fabric
   import wb_soc_pkg::*;
(
   input  wire                                wb_clk_i,
   input  wire                                arst_n_i,
   input  wire wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   output wb_rsp_t [`WB_NUM_MASTERS-1:0]      m_rsp_o,
   output wb_req_t                            ram_req_o,
   output wb_req_t                            uart_req_o,
   input  wire wb_rsp_t                       ram_rsp_i,
   input  wire wb_rsp_t                       uart_rsp_i,
   output logic [`WB_AW-1:0]                  snoop_adr_o,
   output logic                               snoop_en_o
);

   localparam int MIDX_W = (`WB_NUM_MASTERS > 1) ? $clog2(`WB_NUM_MASTERS) : 1;

   logic              gnt_busy;   // Some master owns the bus
   logic [MIDX_W-1:0] gnt_idx;
   logic              nxt_busy;
   logic [MIDX_W-1:0] nxt_idx;
   wb_req_t           gnt_req;
   logic              sel_ram;
   logic              sel_uart;
   logic              err_q;      // Unmapped access response
   wb_rsp_t           slv_rsp;

   //////////////////////////////
   // Arbitration

   always_comb begin
      nxt_busy = gnt_busy;
      nxt_idx  = gnt_idx;
      if (gnt_busy && !m_req_i[gnt_idx].cyc) begin
         nxt_busy = 1'b0;            // Owner is done
      end
      if (!nxt_busy) begin
         // Walking downwards leaves the lowest requesting index
         for (int i = `WB_NUM_MASTERS - 1; i >= 0; i--) begin
            if (m_req_i[i].cyc) begin
               nxt_busy = 1'b1;
               nxt_idx  = MIDX_W'(i);
            end
         end
      end
   end

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gnt_busy <= 1'b0;
         gnt_idx  <= '0;
      end else begin
         gnt_busy <= nxt_busy;
         gnt_idx  <= nxt_idx;
      end
   end

   //////////////////////////////
   // Address decode and request routing

   assign gnt_req  = m_req_i[gnt_idx];
   assign sel_ram  = gnt_req.adr.ram.region == `WB_RAM_REGION;
   assign sel_uart = gnt_req.adr.uart.page == `WB_UART_PAGE;

   always_comb begin
      ram_req_o      = gnt_req;
      ram_req_o.cyc  = gnt_busy & gnt_req.cyc & sel_ram;
      ram_req_o.stb  = gnt_busy & gnt_req.stb & sel_ram;
      uart_req_o     = gnt_req;
      uart_req_o.cyc = gnt_busy & gnt_req.cyc & sel_uart;
      uart_req_o.stb = gnt_busy & gnt_req.stb & sel_uart;
   end

   // One err pulse per unmapped strobe
   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= gnt_busy & gnt_req.cyc & gnt_req.stb & !sel_ram & !sel_uart & !err_q;
      end
   end

   // Response back to the owner only
   always_comb begin
      if (sel_ram) begin
         slv_rsp = ram_rsp_i;
      end else if (sel_uart) begin
         slv_rsp = uart_rsp_i;
      end else begin
         slv_rsp.dat = '0;
         slv_rsp.ack = 1'b0;
         slv_rsp.err = err_q;
      end
      for (int i = 0; i < `WB_NUM_MASTERS; i++) begin
         m_rsp_o[i].dat = slv_rsp.dat;
         m_rsp_o[i].ack = gnt_busy && (gnt_idx == MIDX_W'(i)) && slv_rsp.ack;
         m_rsp_o[i].err = gnt_busy && (gnt_idx == MIDX_W'(i)) && slv_rsp.err;
      end
   end

   // Snoop on every completed RAM write
   assign snoop_en_o  = ram_rsp_i.ack & ram_req_o.we;
   assign snoop_adr_o = ram_req_o.adr;

endmodule

`default_nettype wire

/* wb_soc_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module wb_soc_ram
   import wb_soc_pkg::*;
(
   input  wire          wb_clk_i,
   input  wire          arst_n_i,
   input  wire wb_req_t req_i,
   output wb_rsp_t      rsp_o
);

   localparam int DEPTH = 2 ** `WB_MEM_ADR_BITS;

   logic [`WB_DW-1:0]           mem [DEPTH];
   logic [`WB_MEM_ADR_BITS-1:0] idx;
   logic                        access;
   logic                        ack_q;
   logic [`WB_DW-1:0]           dat_q;

   // Upper word index bits ignored, so the RAM repeats over the region
   assign idx    = req_i.adr.ram.word[`WB_MEM_ADR_BITS-1:0];
   assign access = req_i.cyc & req_i.stb & !ack_q;

   always_ff @(posedge wb_clk_i) begin
      if (access && req_i.we) begin
         for (int b = 0; b < `WB_SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
      if (access) begin
         dat_q <= mem[idx];   // Full word, sel ignored on reads
      end
   end

   // Ack follows stb by one cycle, never back to back
   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

endmodule

`default_nettype wire

/* wb_soc_uart_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module wb_soc_uart_bridge
   import wb_soc_pkg::*;
(
   input  wire wb_req_t  req_i,
   output wb_rsp_t       rsp_o,
   output wb8_req_t      req8_o,
   input  wire wb8_rsp_t rsp8_i
);

   localparam int BOFS_W = `WB_BOFS_W;

   logic [BOFS_W-1:0] ofs;    // Byte offset picked from sel
   logic [7:0]        wdat;

   // Big-endian lanes as on the OpenRISC bus: sel[3] is byte offset 0
   always_comb begin
      ofs  = '0;
      wdat = req_i.dat[`WB_DW-1 -: 8];
      for (int b = 0; b < `WB_SEL_W; b++) begin
         if (req_i.sel[b]) begin
            ofs  = BOFS_W'(`WB_SEL_W - 1 - b);
            wdat = req_i.dat[8*b +: 8];
         end
      end
   end

   always_comb begin
      req8_o.adr              = req_i.adr;
      req8_o.adr.ram.byte_ofs = ofs;        // Word address plus lane
      req8_o.dat              = wdat;
      req8_o.we               = req_i.we;
      req8_o.cyc              = req_i.cyc;
      req8_o.stb              = req_i.stb;
   end

   // Read byte is mirrored so any lane sees it
   assign rsp_o.dat = {`WB_SEL_W{rsp8_i.dat}};
   assign rsp_o.ack = rsp8_i.ack;
   assign rsp_o.err = 1'b0;

endmodule

`default_nettype wire

/* wb_soc_uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module wb_soc_uart_tx
   import wb_soc_pkg::*;
(
   input  wire           wb_clk_i,
   input  wire           arst_n_i,
   input  wire wb8_req_t req_i,
   output wb8_rsp_t      rsp_o,
   output logic          uart_tx_o
);

   localparam int DIV_W = $clog2(`UART_BIT_CYCLES);

   logic             ack_q;
   logic [7:0]       rdat_q;
   logic             access;
   logic             is_thr;
   logic             is_lsr;
   logic             start_tx;
   logic             tx_busy;     // Frame on the line
   logic [8:0]       shreg;       // Data bits, then stop bit
   logic [3:0]       bits_left;
   logic [DIV_W-1:0] div_cnt;
   logic             bit_end;
   logic             tx_q;

   assign access   = req_i.cyc & req_i.stb & !ack_q;
   assign is_thr   = req_i.adr.uart.reg_ofs == `UART_REG_THR;
   assign is_lsr   = req_i.adr.uart.reg_ofs == `UART_REG_LSR;
   assign start_tx = access & req_i.we & is_thr & !tx_busy;  // Busy writes are lost
   assign bit_end  = div_cnt == DIV_W'(`UART_BIT_CYCLES - 1);

   //////////////////////////////
   // Register interface

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (access) begin
         rdat_q <= is_lsr ? {2'b00, !tx_busy, 5'b00000} : 8'h00;  // LSR bit 5 THR empty
      end
   end

   //////////////////////////////
   // Serializer

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_busy   <= 1'b0;
         bits_left <= '0;
         div_cnt   <= '0;
         tx_q      <= 1'b1;   // Line idles high
      end else if (!tx_busy) begin
         if (start_tx) begin
            tx_busy   <= 1'b1;
            bits_left <= 4'd9;
            div_cnt   <= '0;
            tx_q      <= 1'b0;  // Start bit
         end
      end else begin
         div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
         if (bit_end) begin
            if (bits_left == '0) begin
               tx_busy <= 1'b0;   // Stop bit finished
            end else begin
               tx_q      <= shreg[0];
               bits_left <= bits_left - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (start_tx) begin
         shreg <= {1'b1, req_i.dat};
      end else if (tx_busy && bit_end) begin
         shreg <= {1'b1, shreg[8:1]};   // LSB first
      end
   end

   assign rsp_o.dat = rdat_q;
   assign rsp_o.ack = ack_q;
   assign uart_tx_o = tx_q;

endmodule

`default_nettype wire

/* wb_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module wb_soc_top
   import wb_soc_pkg::*;
(
   input  wire                                wb_clk_i,
   input  wire                                arst_n_i,
   input  wire wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   output wb_rsp_t [`WB_NUM_MASTERS-1:0]      m_rsp_o,
   output logic [`WB_AW-1:0]                  snoop_adr_o,
   output logic                               snoop_en_o,
   output logic                               uart_tx_o
);

   wb_req_t  ram_req;
   wb_rsp_t  ram_rsp;
   wb_req_t  uart_req;
   wb_rsp_t  uart_rsp;
   wb8_req_t uart8_req;   // Byte side of the resize bridge
   wb8_rsp_t uart8_rsp;

   wb_soc_fabric wb_soc_fabric_inst (
      .wb_clk_i    (wb_clk_i),
      .arst_n_i    (arst_n_i),
      .m_req_i     (m_req_i),
      .m_rsp_o     (m_rsp_o),
      .ram_req_o   (ram_req),
      .uart_req_o  (uart_req),
      .ram_rsp_i   (ram_rsp),
      .uart_rsp_i  (uart_rsp),
      .snoop_adr_o (snoop_adr_o),
      .snoop_en_o  (snoop_en_o)
   );

   // Main memory
   wb_soc_ram wb_soc_ram_inst (
      .wb_clk_i (wb_clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (ram_req),
      .rsp_o    (ram_rsp)
   );

   // 32 to 8 bit resize in front of the UART
   wb_soc_uart_bridge wb_soc_uart_bridge_inst (
      .req_i  (uart_req),
      .rsp_o  (uart_rsp),
      .req8_o (uart8_req),
      .rsp8_i (uart8_rsp)
   );

   wb_soc_uart_tx wb_soc_uart_tx_inst (
      .wb_clk_i  (wb_clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (uart8_req),
      .rsp_o     (uart8_rsp),
      .uart_tx_o (uart_tx_o)
   );

endmodule

`default_nettype wire

/* wb_soc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module wb_soc_checker
   import wb_soc_pkg::*;
(
   input  wire                                wb_clk_i,
   input  wire                                arst_n_i,
   input  wire wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   input  wire wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_i,
   input  wire                                snoop_en_i
);

   logic ram_wr_ack;   // Some master sees the ack of its RAM write

   always_comb begin
      ram_wr_ack = 1'b0;
      for (int i = 0; i < `WB_NUM_MASTERS; i++) begin
         if (m_rsp_i[i].ack && m_req_i[i].we &&
             m_req_i[i].adr.ram.region == `WB_RAM_REGION) begin
            ram_wr_ack = 1'b1;
         end
      end
   end

   for (genvar g = 0; g < `WB_NUM_MASTERS; g++) begin : g_master
      a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
         !(m_rsp_i[g].ack && m_rsp_i[g].err))
         else $error("Master %0d got ack and err in the same cycle", g);

      // Responses only while the master strobes
      a_rsp_needs_stb: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
         (m_rsp_i[g].ack || m_rsp_i[g].err) |-> m_req_i[g].stb)
         else $error("Master %0d got a response without stb", g);
   end

   a_snoop_on_write: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      snoop_en_i |-> ram_wr_ack)
      else $error("Snoop strobe without a completed RAM write");

endmodule

bind wb_soc_fabric wb_soc_checker wb_soc_checker_inst (
   .wb_clk_i   (wb_clk_i),
   .arst_n_i   (arst_n_i),
   .m_req_i    (m_req_i),
   .m_rsp_i    (m_rsp_o),
   .snoop_en_i (snoop_en_o)
);

`default_nettype wire

/* tb_wb_soc_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module tb_wb_soc_monitor
   import wb_soc_pkg::*;
(
   input  wire                                wb_clk_i,
   input  wire                                arst_n_i,
   input  wire wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   input  wire wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_i,
   input  wire [`WB_AW-1:0]                   snoop_adr_i,
   input  wire                                snoop_en_i,
   input  wire                                uart_tx_i,
   output int                                 err_cnt_o,
   output int                                 frames_o
);

   logic [`WB_DW-1:0] shadow [2**`WB_MEM_ADR_BITS];
   bit                valid  [2**`WB_MEM_ADR_BITS];
   logic [7:0]        tx_exp [$];     // THR bytes not yet seen on the line
   int                bus_errs = 0;
   int                line_errs = 0;

   assign err_cnt_o = bus_errs + line_errs;

   // Bytes with their sel bit set replace the old ones
   function automatic logic [31:0] ref_merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                             input logic [3:0] sel);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // One sel bit names the lane
   function automatic logic [7:0] lane_byte(input logic [31:0] dat, input logic [3:0] sel);
      case (sel)
         4'b1000: return dat[31:24];
         4'b0100: return dat[23:16];
         4'b0010: return dat[15:8];
         4'b0001: return dat[7:0];
         default: return 8'hxx;   // Not a single lane
      endcase
   endfunction

   //////////////////////////////
   // Bus side, compared at every edge
   always @(posedge wb_clk_i) begin : bus_watch
      wb_adr_u                     adr;
      logic [`WB_MEM_ADR_BITS-1:0] idx;
      logic                        snoop_exp;
      logic [`WB_AW-1:0]           snoop_adr_exp;
      snoop_exp     = 1'b0;
      snoop_adr_exp = '0;
      for (int m = 0; m < `WB_NUM_MASTERS; m++) begin
         adr = m_req_i[m].adr;
         idx = adr.ram.word[`WB_MEM_ADR_BITS-1:0];   // Index wraps, higher words alias
         if (arst_n_i === 1'b1 && m_rsp_i[m].ack === 1'b1) begin
            if (adr.ram.region == `WB_RAM_REGION && m_req_i[m].we) begin
               shadow[idx]   = ref_merge(shadow[idx], m_req_i[m].dat, m_req_i[m].sel);
               valid[idx]    = 1'b1;
               snoop_exp     = 1'b1;
               snoop_adr_exp = adr;
            end else if (adr.ram.region == `WB_RAM_REGION) begin
               if (valid[idx] && m_rsp_i[m].dat !== shadow[idx]) begin
                  $display("FAILED at %0t: master %0d read %h from word %0d, expected %h",
                           $time, m, m_rsp_i[m].dat, idx, shadow[idx]);
                  bus_errs++;
               end
            end else if (adr.uart.page == `WB_UART_PAGE && m_req_i[m].we &&
                         adr.uart.reg_ofs == `UART_REG_THR) begin
               tx_exp.push_back(lane_byte(m_req_i[m].dat, m_req_i[m].sel));
            end
         end
      end
      if (arst_n_i === 1'b1 && snoop_en_i !== snoop_exp) begin
         $display("FAILED at %0t: snoop strobe %b, expected %b", $time, snoop_en_i, snoop_exp);
         bus_errs++;
      end else if (snoop_exp && snoop_adr_i !== snoop_adr_exp) begin
         $display("FAILED at %0t: snoop address %h, expected %h",
                  $time, snoop_adr_i, snoop_adr_exp);
         bus_errs++;
      end
   end

   //////////////////////////////
   // Serial line decoder
   initial begin : line_decode
      logic [7:0] rx;
      logic [7:0] exp_b;
      logic       start_ok;
      logic       stop_ok;
      frames_o = 0;
      forever begin
         @(posedge wb_clk_i);
         if (arst_n_i === 1'b1 && uart_tx_i === 1'b0) begin
            repeat (`UART_BIT_CYCLES / 2 - 1) @(posedge wb_clk_i);   // Middle of start bit
            start_ok = uart_tx_i === 1'b0;
            for (int k = 0; k < 8; k++) begin
               repeat (`UART_BIT_CYCLES) @(posedge wb_clk_i);
               rx[k] = uart_tx_i;     // LSB first
            end
            repeat (`UART_BIT_CYCLES) @(posedge wb_clk_i);
            stop_ok = uart_tx_i === 1'b1;
            frames_o++;
            if (tx_exp.size() == 0) begin
               $display("Serial frame with byte %h arrived without a THR write", rx);
               line_errs++;
            end else begin
               exp_b = tx_exp.pop_front();
               if (!start_ok || !stop_ok || rx !== exp_b) begin
                  $display("FAILED at %0t: frame byte %h start %b stop %b, expected byte %h",
                           $time, rx, start_ok, stop_ok, exp_b);
                  line_errs++;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* tb_wb_soc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wb_soc_settings.svh"

module tb_wb_soc
   import wb_soc_pkg::*;
();

   localparam int          TIMEOUT_CYCLES = 4000;  // 4 frames of 160 cycles, bus traffic, margin
   localparam int          NUM_TX_BYTES   = 4;
   localparam logic [31:0] UART_THR_ADR   = 32'hFF80_0000;
   localparam logic [31:0] UART_LSR_ADR   = 32'hFF80_0004;  // LSR sits in lane 1 of this word

   logic                          wb_clk;
   logic                          arst_n;
   wb_req_t                       m0_req;
   wb_req_t                       m1_req;
   wb_req_t [`WB_NUM_MASTERS-1:0] m_req;
   wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp;
   logic [`WB_AW-1:0]             snoop_adr;
   logic                          snoop_en;
   logic                          uart_tx;
   int                            errs;
   int                            mon_errs;
   int                            frames;
   int                            cycles;

   assign m_req = {m1_req, m0_req};

   wb_soc_top wb_soc_top_inst (
      .wb_clk_i    (wb_clk),
      .arst_n_i    (arst_n),
      .m_req_i     (m_req),
      .m_rsp_o     (m_rsp),
      .snoop_adr_o (snoop_adr),
      .snoop_en_o  (snoop_en),
      .uart_tx_o   (uart_tx)
   );

   tb_wb_soc_monitor tb_wb_soc_monitor_inst (
      .wb_clk_i    (wb_clk),
      .arst_n_i    (arst_n),
      .m_req_i     (m_req),
      .m_rsp_i     (m_rsp),
      .snoop_adr_i (snoop_adr),
      .snoop_en_i  (snoop_en),
      .uart_tx_i   (uart_tx),
      .err_cnt_o   (mon_errs),
      .frames_o    (frames)
   );

   initial begin
      wb_clk = 1'b0;
      forever #20 wb_clk = ~wb_clk;
   end

   // Watchdog
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge wb_clk);
         cycles++;
      end
      $display("Timeout: tests did not finish within %0d clock cycles", cycles);
      $display("Simulation failed");
      $finish;
   end

   //////////////////////////////
   // Master ports

   task automatic m0_access(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we,
                            output logic [31:0] rdat, output logic err);
      @(posedge wb_clk);
      m0_req <= {adr, dat, sel, we, 2'b11};   // cyc and stb up
      @(posedge wb_clk);
      while (!m_rsp[0].ack && !m_rsp[0].err) begin
         @(posedge wb_clk);
      end
      rdat = m_rsp[0].dat;
      err  = m_rsp[0].err;
      m0_req <= '0;
   endtask

   task automatic m1_access(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we,
                            output logic [31:0] rdat, output logic err);
      @(posedge wb_clk);
      m1_req <= {adr, dat, sel, we, 2'b11};
      @(posedge wb_clk);
      while (!m_rsp[1].ack && !m_rsp[1].err) begin
         @(posedge wb_clk);
      end
      rdat = m_rsp[1].dat;
      err  = m_rsp[1].err;
      m1_req <= '0;
   endtask

   task automatic check_err(input logic err, input logic [31:0] adr);
      if (err !== 1'b1) begin
         $display("FAILED at %0t: access to unmapped %h gave no err", $time, adr);
         errs++;
      end
   endtask

   initial begin
      logic [31:0] rd0;
      logic [31:0] rd1;
      logic        er0;
      logic        er1;
      logic [31:0] wd;
      void'($urandom(27));
      errs = 0;
      m0_req <= '0;
      m1_req <= '0;
      arst_n <= 1'b0;
      repeat (16) @(posedge wb_clk);
      arst_n <= 1'b1;

      // Full word first, then a random partial overwrite
      for (int i = 0; i < 8; i++) begin
         m0_access(32'(i * 20), $urandom, 4'hF, 1'b1, rd0, er0);
         m0_access(32'(i * 20), $urandom, 4'($urandom), 1'b1, rd0, er0);
      end
      for (int i = 0; i < 8; i++) begin
         m0_access(32'(i * 20), 32'h0, 4'hF, 1'b0, rd0, er0);
      end

      // Both masters in the same cycle, words 100 and 200
      fork
         m0_access(32'h0000_0190, $urandom, 4'hF, 1'b1, rd0, er0);
         m1_access(32'h0000_0320, $urandom, 4'hF, 1'b1, rd1, er1);
      join
      fork
         m0_access(32'h0000_0190, 32'h0, 4'hF, 1'b0, rd0, er0);
         m1_access(32'h0000_0320, 32'h0, 4'hF, 1'b0, rd1, er1);
      join

      // Word 300 seen again 1024 words higher
      wd = $urandom;
      m0_access(32'h0000_04B0, wd, 4'hF, 1'b1, rd0, er0);
      m1_access(32'h0000_14B0, 32'h0, 4'hF, 1'b0, rd1, er1);
      if (rd1 !== wd) begin
         $display("FAILED at %0t: aliased read gave %h, expected %h", $time, rd1, wd);
         errs++;
      end

      m0_access(32'h1000_0014, $urandom, 4'hF, 1'b1, rd0, er0);
      check_err(er0, 32'h1000_0014);
      m1_access(32'hFF80_0008, 32'h0, 4'hF, 1'b0, rd1, er1);   // Just past the UART page
      check_err(er1, 32'hFF80_0008);
      m0_access(32'h0000_0014, 32'h0, 4'hF, 1'b0, rd0, er0);   // Word 5 untouched

      //////////////////////////////
      // UART transmit with LSR polling
      for (int k = 0; k <= NUM_TX_BYTES; k++) begin
         do begin
            m1_access(UART_LSR_ADR, 32'h0, 4'b0100, 1'b0, rd1, er1);
         end while (!rd1[5]);
         if (k < NUM_TX_BYTES) begin
            m1_access(UART_THR_ADR, {8'($urandom), 24'h0}, 4'b1000, 1'b1, rd1, er1);
         end
      end
      if (frames != NUM_TX_BYTES) begin
         $display("Only %0d of %0d serial frames were decoded", frames, NUM_TX_BYTES);
         errs++;
      end

      repeat (4) @(posedge wb_clk);
      $display("Errors: testbench %0d, monitor %0d", errs, mon_errs);
      if (errs == 0 && mon_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* wb_soc.f */
+incdir+.
wb_soc_pkg.sv
wb_soc_fabric.sv
wb_soc_ram.sv
wb_soc_uart_bridge.sv
wb_soc_uart_tx.sv
wb_soc_top.sv
wb_soc_checker.sv
tb_wb_soc_monitor.sv
tb_wb_soc.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f wb_soc.f --top-module tb_wb_soc -o tb_wb_soc_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_wb_soc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
exit 1
